// ==== sim.f ====
rtl/pcm_pkg.sv
rtl/voice_regs.sv
rtl/voice_fetch.sv
rtl/sample_cache.sv
rtl/pcm_sample_top.sv
tests/pcm_sample_properties.sv
tests/tb_pcm_sample_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the PCM sample fetch simulation with Verilator
set -u

cd "$(dirname "$0")"

TOP=tb_pcm_sample_top
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

// ==== tests/tb_pcm_sample_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pcm_sample_top
    import pcm_pkg::*;
();

    localparam int NUM_VOICES    = 4;
    localparam int VSEL_W        = $clog2(NUM_VOICES);
    localparam logic [SDR_ADDR_W-1:0] ROM_BASE = 25'h0100000;
    localparam int FRAME_TIMEOUT = 500;
    localparam int NUM_ROWS      = 4;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    reg_we;
    logic [VSEL_W-1:0]       reg_voice;
    reg_field_e              reg_field;
    logic [ADDR_W-1:0]       reg_wdata;
    logic                    sample_tick;
    mix_t                    mix_out;
    logic                    mix_valid;
    logic [NUM_VOICES-1:0]   voice_busy;
    logic [SDR_ADDR_W-1:0]   sdr_addr;
    logic [LINE_W-1:0]       sdr_data;
    logic                    sdr_req;
    logic                    sdr_rdy;

    // Single-voice plays: name, voice, region, volume, frames, SDRAM requests
    string             row_name  [NUM_ROWS] = '{"single_voice", "line_reuse", "short_region",
                                                "one_byte"};
    int                row_voice [NUM_ROWS] = '{1, 2, 0, 3};
    logic [ADDR_W-1:0] row_start [NUM_ROWS] = '{20'h05C7C, 20'h31A40, 20'h7E3FE, 20'h000F3};
    logic [ADDR_W-1:0] row_end   [NUM_ROWS] = '{20'h05C84, 20'h31A47, 20'h7E401, 20'h000F3};
    logic [7:0]        row_vol   [NUM_ROWS] = '{8'd200, 8'd97, 8'd255, 8'd3};
    int                row_ticks [NUM_ROWS] = '{9, 8, 4, 1};
    int                row_reqs  [NUM_ROWS] = '{2, 1, 2, 1};

    // Software voice model
    logic [ADDR_W-1:0]     model_start [NUM_VOICES];
    logic [ADDR_W-1:0]     model_end   [NUM_VOICES];
    logic [ADDR_W-1:0]     model_addr  [NUM_VOICES];
    logic [7:0]            model_vol   [NUM_VOICES];
    logic [NUM_VOICES-1:0] model_busy;

    int                    strobe_count = 0;
    int                    req_count = 0;
    logic [SDR_ADDR_W-1:0] last_req_addr;
    int                    mix_errors = 0;
    int                    busy_errors = 0;
    int                    count_errors = 0;
    int                    timeout_errors = 0;

    pcm_sample_top i_pcm_sample_top (
        .clk         (clk),
        .reset       (reset),
        .reg_we      (reg_we),
        .reg_voice   (reg_voice),
        .reg_field   (reg_field),
        .reg_wdata   (reg_wdata),
        .sample_tick (sample_tick),
        .mix_out     (mix_out),
        .mix_valid   (mix_valid),
        .voice_busy  (voice_busy),
        .sdr_addr    (sdr_addr),
        .sdr_data    (sdr_data),
        .sdr_req     (sdr_req),
        .sdr_rdy     (sdr_rdy)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (mix_valid === 1'b1) begin
            strobe_count <= strobe_count + 1;
        end
        if (sdr_req === 1'b1) begin
            req_count     <= req_count + 1;
            last_req_addr <= sdr_addr;
        end
    end

    function automatic sample_t rom_byte(input logic [ADDR_W-1:0] a);
        return sample_t'(a[7:0] ^ a[15:8]);
    endfunction

    function automatic logic [LINE_W-1:0] line_data(input logic [ADDR_W-1:0] base);
        logic [LINE_W-1:0] d;
        for (int k = 0; k < 8; k++) begin
            d[8*k +: 8] = rom_byte(base + ADDR_W'(k));
        end
        return d;
    endfunction

    // SDRAM answers each request after 2 to 9 cycles
    initial begin : sdram_model
        logic [SDR_ADDR_W-1:0] line_addr;
        int delay;
        sdr_rdy  = 1'b0;
        sdr_data = '0;
        void'($urandom(32'h1c368c86));
        forever begin
            @(posedge clk);
            if (sdr_req === 1'b1) begin
                line_addr = sdr_addr;
                delay     = 2 + int'($urandom % 8);
                repeat (delay - 1) @(posedge clk);
                sdr_data <= line_data(ADDR_W'(line_addr - ROM_BASE));
                sdr_rdy  <= 1'b1;
                @(posedge clk);
                sdr_rdy  <= 1'b0;
            end
        end
    end

    // Expected mix of the next frame, then step every playing voice
    function automatic mix_t model_frame();
        int sum;
        sum = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (model_busy[v]) begin
                sum += int'(rom_byte(model_addr[v])) * int'(model_vol[v]);
                if (model_addr[v] == model_end[v]) begin
                    model_busy[v] = 1'b0;
                end else begin
                    model_addr[v] = model_addr[v] + 1'b1;
                end
            end
        end
        return mix_t'(sum);
    endfunction

    task automatic check_mix(input string name, input mix_t expected, input mix_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: mix expected %0d, actual %0d", name, expected, actual);
            mix_errors++;
        end
    endtask

    task automatic check_busy(input string name, input logic [NUM_VOICES-1:0] expected,
                              input logic [NUM_VOICES-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: voice_busy expected %b, actual %b", name, expected, actual);
            busy_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] %s: count expected %0d, actual %0d", name, expected, actual);
            count_errors++;
        end
    endtask

    task automatic write_reg(input int v, input reg_field_e field, input logic [ADDR_W-1:0] data);
        @(posedge clk);
        reg_we    <= 1'b1;
        reg_voice <= VSEL_W'(v);
        reg_field <= field;
        reg_wdata <= data;
        @(posedge clk);
        reg_we    <= 1'b0;
    endtask

    task automatic start_voice(input int v, input logic [ADDR_W-1:0] first,
                               input logic [ADDR_W-1:0] last, input logic [7:0] vol);
        write_reg(v, FIELD_START, first);
        write_reg(v, FIELD_END, last);
        write_reg(v, FIELD_VOLUME, ADDR_W'(vol));
        write_reg(v, FIELD_KEY, 20'h1);
        model_start[v] = first;
        model_end[v]   = last;
        model_vol[v]   = vol;
        model_addr[v]  = first;
        model_busy[v]  = 1'b1;
        // key_on pulse, then busy
        repeat (2) @(posedge clk);
    endtask

    task automatic wait_mix(input string name, output bit seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < FRAME_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (mix_valid === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("%s: no mix_valid within %0d cycles of the tick", name, FRAME_TIMEOUT);
            timeout_errors++;
        end
    endtask

    task automatic run_frame(input string name);
        mix_t expected;
        bit   seen;
        expected = model_frame();
        @(posedge clk);
        sample_tick <= 1'b1;
        @(posedge clk);
        sample_tick <= 1'b0;
        wait_mix(name, seen);
        if (seen) begin
            check_mix(name, expected, mix_out);
            check_busy(name, model_busy, voice_busy);
        end
    endtask

    task automatic run_until_idle(input string name, input int max_frames);
        int n;
        n = 0;
        while (model_busy != '0 && n < max_frames) begin
            run_frame(name);
            n++;
        end
        check_busy(name, '0, voice_busy);
    endtask

    task automatic play_row(input int r);
        int reqs_before;
        reqs_before = req_count;
        start_voice(row_voice[r], row_start[r], row_end[r], row_vol[r]);
        repeat (row_ticks[r]) run_frame(row_name[r]);
        check_busy(row_name[r], '0, voice_busy);
        check_count(row_name[r], row_reqs[r], req_count - reqs_before);
        // A single refill must target the start's line
        if (row_reqs[r] == 1) begin
            check_count(row_name[r], int'(ROM_BASE) + int'({row_start[r][ADDR_W-1:3], 3'b000}),
                        int'(last_req_addr));
        end
    endtask

    task automatic ignored_tick();
        int   strobes_before;
        bit   seen;
        mix_t expected;
        start_voice(3, 20'h3C3C5, 20'h3C3C5, 8'd60);
        expected       = model_frame();
        strobes_before = strobe_count;
        @(posedge clk);
        sample_tick <= 1'b1;
        // Still high while the frame runs
        repeat (3) @(posedge clk);
        sample_tick <= 1'b0;
        wait_mix("ignored_tick", seen);
        if (seen) begin
            check_mix("ignored_tick", expected, mix_out);
        end
        repeat (30) @(posedge clk);
        check_count("ignored_tick", 1, strobe_count - strobes_before);
        check_busy("ignored_tick", '0, voice_busy);
    endtask

    initial begin
        int total;
        reset       = 1'b1;
        reg_we      = 1'b0;
        reg_voice   = '0;
        reg_field   = FIELD_START;
        reg_wdata   = '0;
        sample_tick = 1'b0;
        model_busy  = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        check_count("reset", 0, (sdr_req === 1'b0) ? 0 : 1);
        check_count("reset", 0, (mix_valid === 1'b0) ? 0 : 1);
        check_busy("reset", '0, voice_busy);
        run_frame("idle_tick");

        for (int r = 0; r < NUM_ROWS; r++) begin
            play_row(r);
        end

        start_voice(0, 20'h12340, 20'h1234B, 8'd40);
        start_voice(1, 20'h4A7F9, 20'h4A802, 8'd255);
        start_voice(2, 20'h66F00, 20'h66F05, 8'd128);
        start_voice(3, 20'h0D0D6, 20'h0D0E1, 8'd7);
        check_busy("four_voices", '1, voice_busy);
        run_until_idle("four_voices", 20);

        // Restart voice 1 partway through its region
        start_voice(1, 20'h2B2B0, 20'h2B2BF, 8'd150);
        repeat (5) run_frame("restart");
        write_reg(1, FIELD_KEY, 20'h1);
        model_addr[1] = model_start[1];
        repeat (2) @(posedge clk);
        run_until_idle("restart", 40);

        ignored_tick();

        total = mix_errors + busy_errors + count_errors + timeout_errors;
        $display("errors: mix %0d, busy %0d, count %0d, timeout %0d",
                 mix_errors, busy_errors, count_errors, timeout_errors);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/pcm_sample_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcm_sample_properties (
    input wire clk,
    input wire reset,
    input wire sdr_req,
    input wire sdr_rdy,
    input wire mix_valid
);

    logic req_outstanding;

    // Set by a refill request, cleared by the SDRAM answer
    always_ff @(posedge clk) begin
        if (reset) begin
            req_outstanding <= 1'b0;
        end else if (sdr_req) begin
            req_outstanding <= 1'b1;
        end else if (sdr_rdy) begin
            req_outstanding <= 1'b0;
        end
    end

    req_is_pulse: assert property (@(posedge clk) disable iff (reset) sdr_req |=> !sdr_req)
        else $error("sdr_req stayed high for more than one cycle");

    one_req_in_flight: assert property (@(posedge clk) disable iff (reset)
        sdr_req |-> !req_outstanding)
        else $error("second sdr_req issued before sdr_rdy answered the first");

    mix_is_pulse: assert property (@(posedge clk) disable iff (reset) mix_valid |=> !mix_valid)
        else $error("mix_valid stayed high for more than one cycle");

endmodule

bind pcm_sample_top pcm_sample_properties i_pcm_sample_properties (
    .clk       (clk),
    .reset     (reset),
    .sdr_req   (sdr_req),
    .sdr_rdy   (sdr_rdy),
    .mix_valid (mix_valid)
);

`default_nettype wire

// ==== rtl/pcm_sample_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcm_sample_top
    import pcm_pkg::*;
#(
    parameter int                    NUM_VOICES  = 4,
    parameter int                    CACHE_LINES = 12,
    parameter logic [SDR_ADDR_W-1:0] ROM_BASE    = 25'h0100000
) (
    input  wire                             clk,
    input  wire                             reset,

    input  wire                             reg_we,
    input  wire [$clog2(NUM_VOICES)-1:0]    reg_voice,
    input  wire reg_field_e                 reg_field,
    input  wire [ADDR_W-1:0]                reg_wdata,

    input  wire                             sample_tick,
    output mix_t                            mix_out,
    output logic                            mix_valid,
    output logic [NUM_VOICES-1:0]           voice_busy,

    output logic [SDR_ADDR_W-1:0]           sdr_addr,
    input  wire [LINE_W-1:0]                sdr_data,
    output logic                            sdr_req,
    input  wire                             sdr_rdy
);

    logic [NUM_VOICES*ADDR_W-1:0] start_addr;
    logic [NUM_VOICES*ADDR_W-1:0] end_addr;
    logic [NUM_VOICES*VOL_W-1:0]  volume;
    logic [NUM_VOICES-1:0]        key_on;

    logic                         rd;
    logic [ADDR_W-1:0]            addr;
    logic                         valid;
    sample_t                      dout;

    voice_regs #(
        .NUM_VOICES (NUM_VOICES)
    ) i_voice_regs (
        .clk        (clk),
        .reset      (reset),
        .reg_we     (reg_we),
        .reg_voice  (reg_voice),
        .reg_field  (reg_field),
        .reg_wdata  (reg_wdata),
        .start_addr (start_addr),
        .end_addr   (end_addr),
        .volume     (volume),
        .key_on     (key_on)
    );

    voice_fetch #(
        .NUM_VOICES (NUM_VOICES)
    ) i_voice_fetch (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .start_addr  (start_addr),
        .end_addr    (end_addr),
        .volume      (volume),
        .key_on      (key_on),
        .rd          (rd),
        .addr        (addr),
        .valid       (valid),
        .dout        (dout),
        .mix_out     (mix_out),
        .mix_valid   (mix_valid),
        .voice_busy  (voice_busy)
    );

    sample_cache #(
        .CACHE_LINES (CACHE_LINES),
        .ROM_BASE    (ROM_BASE)
    ) i_sample_cache (
        .clk      (clk),
        .reset    (reset),
        .rd       (rd),
        .addr     (addr),
        .valid    (valid),
        .dout     (dout),
        .sdr_addr (sdr_addr),
        .sdr_data (sdr_data),
        .sdr_req  (sdr_req),
        .sdr_rdy  (sdr_rdy)
    );

endmodule

`default_nettype wire

// ==== rtl/sample_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_cache
    import pcm_pkg::*;
#(
    parameter int                    CACHE_LINES = 12,
    parameter logic [SDR_ADDR_W-1:0] ROM_BASE    = 25'h0100000
) (
    input  wire                     clk,
    input  wire                     reset,

    input  wire                     rd,
    input  wire [ADDR_W-1:0]        addr,
    output logic                    valid,
    output sample_t                 dout,

    output logic [SDR_ADDR_W-1:0]   sdr_addr,
    input  wire [LINE_W-1:0]        sdr_data,
    output logic                    sdr_req,
    input  wire                     sdr_rdy
);

    localparam int IDX_W   = $clog2(CACHE_LINES);
    localparam int STAMP_W = $clog2(CACHE_LINES + 1);

    line_state_e        state_q [CACHE_LINES];
    logic [TAG_W-1:0]   tag_q   [CACHE_LINES];
    logic [LINE_W-1:0]  data_q  [CACHE_LINES];
    logic [STAMP_W-1:0] stamp_q [CACHE_LINES];

    logic               rq;
    logic               ack;
    logic               rq_active;
    logic [IDX_W-1:0]   rq_index;
    logic               read_missed;
    logic [TAG_W-1:0]   read_tag;
    logic [LINE_W-1:0]  fill_data;

    logic [TAG_W-1:0]   rd_tag;
    logic               hit;
    logic [IDX_W-1:0]   hit_idx;
    logic               pend_match;
    logic               victim_found;
    logic [IDX_W-1:0]   victim_idx;
    logic [STAMP_W-1:0] victim_stamp;
    logic               req_found;
    logic [IDX_W-1:0]   req_idx;
    logic               fill_done;

    assign rd_tag = addr[ADDR_W-1:3];

    always_comb begin
        hit          = 1'b0;
        hit_idx      = '0;
        pend_match   = 1'b0;
        victim_found = 1'b0;
        victim_idx   = '0;
        victim_stamp = '0;
        req_found    = 1'b0;
        req_idx      = '0;
        for (int i = 0; i < CACHE_LINES; i++) begin
            // A tag already in flight must not be allocated twice
            if (tag_q[i] == rd_tag) begin
                if (state_q[i] == VALID) begin
                    hit     = 1'b1;
                    hit_idx = IDX_W'(i);
                end else begin
                    pend_match = 1'b1;
                end
            end
            // Oldest valid line, stamp zero first
            if (state_q[i] == VALID && (!victim_found || stamp_q[i] < victim_stamp)) begin
                victim_found = 1'b1;
                victim_idx   = IDX_W'(i);
                victim_stamp = stamp_q[i];
            end
            if (!req_found && state_q[i] == PENDING_RQ) begin
                req_found = 1'b1;
                req_idx   = IDX_W'(i);
            end
        end
    end

    assign fill_done = rq_active && (rq == ack);

    // Acknowledge follows the request bit while the SDRAM answers
    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else if (sdr_rdy) begin
            ack <= rq;
        end
    end

    always_ff @(posedge clk) begin
        if (sdr_rdy) begin
            fill_data <= sdr_data;
        end
        if (fill_done && state_q[rq_index] == PENDING_ACK) begin
            data_q[rq_index] <= fill_data;
        end
    end

    always_ff @(posedge clk) begin
        sdr_req <= 1'b0;
        valid   <= 1'b0;
        if (reset) begin
            for (int i = 0; i < CACHE_LINES; i++) begin
                state_q[i] <= VALID;
                tag_q[i]   <= '1;
                stamp_q[i] <= '0;
            end
            rq          <= 1'b0;
            rq_active   <= 1'b0;
            read_missed <= 1'b0;
        end else begin
            if (rq_active) begin
                if (fill_done) begin
                    rq_active <= 1'b0;
                    if (state_q[rq_index] == PENDING_ACK) begin
                        state_q[rq_index] <= VALID;
                        stamp_q[rq_index] <= STAMP_W'(CACHE_LINES);
                    end
                end
            end else if (req_found) begin
                rq_index         <= req_idx;
                rq_active        <= 1'b1;
                sdr_req          <= 1'b1;
                sdr_addr         <= ROM_BASE + SDR_ADDR_W'({tag_q[req_idx], 3'b000});
                rq               <= ~rq;
                state_q[req_idx] <= PENDING_ACK;
            end

            if (rd) begin
                read_tag    <= rd_tag;
                read_missed <= !hit && !pend_match;
                for (int i = 0; i < CACHE_LINES; i++) begin
                    if (state_q[i] == VALID && stamp_q[i] != 0) begin
                        stamp_q[i] <= stamp_q[i] - 1'b1;
                    end
                end
                if (hit) begin
                    valid            <= 1'b1;
                    dout             <= data_q[hit_idx][{addr[2:0], 3'b000} +: 8];
                    stamp_q[hit_idx] <= STAMP_W'(CACHE_LINES);
                end
            end else if (read_missed) begin
                // Claim the victim once rd has dropped
                read_missed <= 1'b0;
                if (victim_found) begin
                    state_q[victim_idx] <= PENDING_RQ;
                    tag_q[victim_idx]   <= read_tag;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/voice_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module voice_fetch
    import pcm_pkg::*;
#(
    parameter int NUM_VOICES = 4
) (
    input  wire                             clk,
    input  wire                             reset,

    input  wire                             sample_tick,

    input  wire [NUM_VOICES*ADDR_W-1:0]     start_addr,
    input  wire [NUM_VOICES*ADDR_W-1:0]     end_addr,
    input  wire [NUM_VOICES*VOL_W-1:0]      volume,
    input  wire [NUM_VOICES-1:0]            key_on,

    output logic                            rd,
    output logic [ADDR_W-1:0]               addr,
    input  wire                             valid,
    input  wire sample_t                    dout,

    output mix_t                            mix_out,
    output logic                            mix_valid,
    output logic [NUM_VOICES-1:0]           voice_busy
);

    localparam int VW = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1;
    localparam int IW = $clog2(NUM_VOICES + 1);

    fetch_state_e      state;
    logic [ADDR_W-1:0] cur_addr [NUM_VOICES];
    logic [IW-1:0]     scan_from;
    logic [VW-1:0]     cur_v;
    mix_t              acc;

    logic              next_found;
    logic [VW-1:0]     next_v;
    logic [VOL_W-1:0]  cur_vol;
    logic [ADDR_W-1:0] cur_end;
    logic signed [VOL_W+8:0] product;

    // First busy voice at or above the scan position
    always_comb begin
        next_found = 1'b0;
        next_v     = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (!next_found && voice_busy[i] && (i >= scan_from)) begin
                next_found = 1'b1;
                next_v     = VW'(i);
            end
        end
    end

    assign cur_vol = volume[cur_v*VOL_W +: VOL_W];
    assign cur_end = end_addr[cur_v*ADDR_W +: ADDR_W];
    // Volume is unsigned, so widen before the signed multiply
    assign product = dout * $signed({1'b0, cur_vol});

    assign rd   = (state == ISSUE);
    assign addr = cur_addr[cur_v];

    always_ff @(posedge clk) begin
        mix_valid <= 1'b0;
        if (reset) begin
            state      <= IDLE;
            voice_busy <= '0;
            scan_from  <= '0;
            cur_v      <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (sample_tick) begin
                        acc       <= '0;
                        scan_from <= '0;
                        state     <= NEXT;
                    end
                end
                NEXT: begin
                    if (next_found) begin
                        cur_v <= next_v;
                        state <= ISSUE;
                    end else begin
                        mix_out   <= acc;
                        mix_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                ISSUE: begin
                    state <= WAIT;
                end
                WAIT: begin
                    // A miss sends us back to re-issue after this idle cycle
                    if (valid) begin
                        acc <= acc + product;
                        if (cur_addr[cur_v] == cur_end) begin
                            voice_busy[cur_v] <= 1'b0;
                        end else begin
                            cur_addr[cur_v] <= cur_addr[cur_v] + 1'b1;
                        end
                        scan_from <= IW'(cur_v) + 1'b1;
                        state     <= NEXT;
                    end else begin
                        state <= ISSUE;
                    end
                end
                default: state <= IDLE;
            endcase

            // Key-on wins over a same-cycle advance
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (key_on[v]) begin
                    cur_addr[v]   <= start_addr[v*ADDR_W +: ADDR_W];
                    voice_busy[v] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/voice_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module voice_regs
    import pcm_pkg::*;
#(
    parameter int NUM_VOICES = 4
) (
    input  wire                             clk,
    input  wire                             reset,

    input  wire                             reg_we,
    input  wire [$clog2(NUM_VOICES)-1:0]    reg_voice,
    input  wire reg_field_e                 reg_field,
    input  wire [ADDR_W-1:0]                reg_wdata,

    output logic [NUM_VOICES*ADDR_W-1:0]    start_addr,
    output logic [NUM_VOICES*ADDR_W-1:0]    end_addr,
    output logic [NUM_VOICES*VOL_W-1:0]     volume,
    output logic [NUM_VOICES-1:0]           key_on
);

    logic [NUM_VOICES-1:0] voice_sel;
    logic                  wr_start;
    logic                  wr_end;
    logic                  wr_volume;
    logic                  wr_key;

    // One-hot voice select, only while a write is presented
    always_comb begin
        voice_sel = '0;
        if (reg_we) begin
            voice_sel[reg_voice] = 1'b1;
        end
    end

    assign wr_start  = (reg_field == FIELD_START);
    assign wr_end    = (reg_field == FIELD_END);
    assign wr_volume = (reg_field == FIELD_VOLUME);
    assign wr_key    = (reg_field == FIELD_KEY);

    // Region bounds
    always_ff @(posedge clk) begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (voice_sel[v] && wr_start) begin
                start_addr[v*ADDR_W +: ADDR_W] <= reg_wdata;
            end
            if (voice_sel[v] && wr_end) begin
                end_addr[v*ADDR_W +: ADDR_W] <= reg_wdata;
            end
        end
    end

    // Volume and key pulses
    always_ff @(posedge clk) begin
        key_on <= '0;
        if (reset) begin
            volume <= '0;
        end else begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (voice_sel[v] && wr_volume) begin
                    volume[v*VOL_W +: VOL_W] <= reg_wdata[VOL_W-1:0];
                end
                // Bit 0 clear is a no-op write
                if (voice_sel[v] && wr_key) begin
                    key_on[v] <= reg_wdata[0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pcm_pkg.sv ====
`default_nettype none

package pcm_pkg;

    // Sample ROM and SDRAM geometry
    localparam int ADDR_W     = 20;
    localparam int SDR_ADDR_W = 25;
    localparam int LINE_W     = 64;
    localparam int TAG_W      = ADDR_W - 3;

    localparam int MIX_W = 18;
    localparam int VOL_W = 8;

    typedef logic signed [7:0]       sample_t;
    typedef logic signed [MIX_W-1:0] mix_t;

    typedef enum logic [1:0] {
        FIELD_START,
        FIELD_END,
        FIELD_VOLUME,
        FIELD_KEY
    } reg_field_e;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        NEXT
    } fetch_state_e;

    typedef enum logic [1:0] {
        PENDING_RQ,
        PENDING_ACK,
        VALID
    } line_state_e;

endpackage

`default_nettype wire
